// ==== Makefile ====
BIN := obj_dir/VcpuTb
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(BIN): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module cpuTb -f tb.f

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== hw/alu.sv ====
module alu import cpuPkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  imm8_t   imm8,
  input  opcode_t opcode,
  output word_t   result,
  output flags_t  flags
);

  word_t      sum;
  word_t      diff;
  word_t      memAddr;
  word_t      rotated;
  logic [3:0] shamt;
  logic       ovfl;

  // shift amount comes from the low nibble of the rt register value
  assign shamt = b[3:0];

  assign sum  = a + b;
  assign diff = a - b;

  // base plus sign-extended 4-bit offset for LW and SW
  assign memAddr = a + {{12{imm8[3]}}, imm8[3:0]};

  // a zero amount leaves the left part empty, so a passes unchanged
  assign rotated = (a >> shamt) | (a << (5'd16 - shamt));

  // signed overflow, only meaningful for ADD and SUB
  always_comb begin
    case (opcode)
      opAdd:   ovfl = (a[15] == b[15]) && (sum[15] != a[15]);
      opSub:   ovfl = (a[15] != b[15]) && (diff[15] != a[15]);
      default: ovfl = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      opAdd:       result = sum;
      opSub:       result = diff;
      opXor:       result = a ^ b;
      opAnd:       result = a & b;
      opSll:       result = a << shamt;
      opSra:       result = word_t'($signed(a) >>> shamt);
      opRor:       result = rotated;
      opLw, opSw:  result = memAddr;
      // b carries rd here so the untouched byte survives
      opLlb:       result = {b[15:8], imm8};
      opLhb:       result = {imm8, b[7:0]};
      default:     result = '0;
    endcase
  end

  assign flags = {result[15], result == '0, ovfl};

endmodule

// ==== hw/branchUnit.sv ====
module branchUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  opcode_t opcode,
  input  cond_t   cond,
  input  off9_t   off9,
  input  word_t   target,
  input  flags_t  aluFlags,
  input  logic    halt,
  output word_t   pc,
  output word_t   pcPlus1
);

  flags_t flags;
  logic   flagN, flagZ, flagV;
  logic   weN, weZ, weV;
  logic   condMet;
  word_t  branchTarget;
  word_t  nextPc;

  assign {flagN, flagZ, flagV} = flags;

  // N and V only from ADD/SUB, Z also from XOR and the shifts
  assign weN = opcode inside {opAdd, opSub};
  assign weV = weN;
  assign weZ = opcode inside {opAdd, opSub, opXor, opSll, opSra, opRor};

  always_comb begin
    case (cond)
      3'b000:  condMet = !flagZ;
      3'b001:  condMet = flagZ;
      3'b010:  condMet = !flagZ && !flagN;
      3'b011:  condMet = flagN;
      3'b100:  condMet = !flagN;
      3'b101:  condMet = flagZ || flagN;
      3'b110:  condMet = flagV;
      default: condMet = 1'b1;
    endcase
  end

  assign pcPlus1      = pc + 16'd1;
  assign branchTarget = pcPlus1 + {{7{off9[8]}}, off9};

  always_comb begin
    if (halt) begin
      nextPc = pc;
    end else if (opcode == opB && condMet) begin
      nextPc = branchTarget;
    end else if (opcode == opBr && condMet) begin
      nextPc = target;
    end else begin
      nextPc = pcPlus1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= '0;
      flags <= '0;
    end else begin
      pc <= nextPc;
      if (weN) flags[2] <= aluFlags[2];
      if (weZ) flags[1] <= aluFlags[1];
      if (weV) flags[0] <= aluFlags[0];
    end
  end

endmodule

// ==== hw/cpu.sv ====
module cpu import cpuPkg::*; #(
  parameter int instAddrWidth = 8,
  parameter int dataAddrWidth = 8
) (
  input  logic    clk,
  input  logic    reset,
  output logic    hlt,
  output word_t   pc,
  input  logic    progWe,
  input  word_t   progAddr,
  input  word_t   progData,
  input  regIdx_t dbgReg,
  output word_t   dbgData
);

  word_t   instruction;
  word_t   instAddr;
  logic    instWe;
  opcode_t opcode;
  regIdx_t rd, rs, rt;
  imm8_t   imm8;
  off9_t   off9;
  cond_t   cond;
  logic    regWe, memWe, halt;
  logic    regWeGated, memWeGated;
  word_t   srcA, srcB;
  word_t   result;
  flags_t  aluFlags;
  word_t   pcPlus1;
  word_t   dataOut;
  word_t   writeData;

  // program port owns the instruction memory during reset
  assign instAddr = reset ? progAddr : pc;
  assign instWe   = reset && progWe;

  memory #(.addrWidth(instAddrWidth)) instMem (
    .clk(clk), .we(instWe), .addr(instAddr), .wdata(progData), .rdata(instruction)
  );

  decoder decoder_i (
    .instruction(instruction), .opcode(opcode), .rd(rd), .rs(rs), .rt(rt),
    .imm8(imm8), .off9(off9), .cond(cond), .regWe(regWe), .memWe(memWe), .halt(halt)
  );

  // no architectural writes in reset or once halted
  assign regWeGated = regWe && !reset && !halt;
  assign memWeGated = memWe && !reset && !halt;
  assign hlt        = halt && !reset;

  always_comb begin
    case (opcode)
      opPcs:   writeData = pcPlus1;
      opLw:    writeData = dataOut;
      default: writeData = result;
    endcase
  end

  registerFile regFile (
    .clk(clk), .reset(reset), .rs(rs), .rt(rt), .rd(rd), .we(regWeGated),
    .wdata(writeData), .dbgReg(dbgReg), .srcA(srcA), .srcB(srcB), .dbgData(dbgData)
  );

  alu alu_i (
    .a(srcA), .b(srcB), .imm8(imm8), .opcode(opcode), .result(result), .flags(aluFlags)
  );

  // BR target is the value of rs
  branchUnit branch (
    .clk(clk), .reset(reset), .opcode(opcode), .cond(cond), .off9(off9), .target(srcA),
    .aluFlags(aluFlags), .halt(halt), .pc(pc), .pcPlus1(pcPlus1)
  );

  memory #(.addrWidth(dataAddrWidth)) dataMem (
    .clk(clk), .we(memWeGated), .addr(result), .wdata(srcB), .rdata(dataOut)
  );

endmodule

// ==== hw/cpuPkg.sv ====
package cpuPkg;

  // datapath word, also used for addresses and instructions
  typedef logic [15:0] word_t;

  typedef logic [3:0] regIdx_t;
  typedef logic [3:0] opcode_t;
  typedef logic [2:0] cond_t;

  // N, Z, V from msb to lsb
  typedef logic [2:0] flags_t;

  typedef logic [7:0] imm8_t;
  typedef logic [8:0] off9_t;

  // arithmetic, logic and shift group
  localparam opcode_t opAdd = 4'b0000;
  localparam opcode_t opSub = 4'b0001;
  localparam opcode_t opXor = 4'b0010;
  localparam opcode_t opAnd = 4'b0011;
  localparam opcode_t opSll = 4'b0100;
  localparam opcode_t opSra = 4'b0101;
  localparam opcode_t opRor = 4'b0110;
  localparam opcode_t opNop = 4'b0111;

  // memory and immediate loads
  localparam opcode_t opLw  = 4'b1000;
  localparam opcode_t opSw  = 4'b1001;
  localparam opcode_t opLlb = 4'b1010;
  localparam opcode_t opLhb = 4'b1011;

  // control flow
  localparam opcode_t opB   = 4'b1100;
  localparam opcode_t opBr  = 4'b1101;
  localparam opcode_t opPcs = 4'b1110;
  localparam opcode_t opHlt = 4'b1111;

endpackage

// ==== hw/decoder.sv ====
module decoder import cpuPkg::*; (
  input  word_t   instruction,
  output opcode_t opcode,
  output regIdx_t rd,
  output regIdx_t rs,
  output regIdx_t rt,
  output imm8_t   imm8,
  output off9_t   off9,
  output cond_t   cond,
  output logic    regWe,
  output logic    memWe,
  output logic    halt
);

  // fixed field positions, each op picks what it needs
  assign opcode = instruction[15:12];
  assign rd     = instruction[11:8];
  assign rs     = instruction[7:4];
  assign imm8   = instruction[7:0];
  assign off9   = instruction[8:0];
  assign cond   = instruction[11:9];

  // second read port looks at rd when rd is a source
  always_comb begin
    if (opcode inside {opSw, opLlb, opLhb}) begin
      rt = instruction[11:8];
    end else begin
      rt = instruction[3:0];
    end
  end

  always_comb begin
    case (opcode)
      opAdd, opSub, opXor, opAnd, opSll, opSra, opRor: regWe = 1'b1;
      opLw, opLlb, opLhb, opPcs:                        regWe = 1'b1;
      default:                                          regWe = 1'b0;
    endcase
  end

  assign memWe = (opcode == opSw);
  assign halt  = (opcode == opHlt);

endmodule

// ==== hw/memory.sv ====
module memory import cpuPkg::*; #(
  parameter int addrWidth = 8
) (
  input  logic  clk,
  input  logic  we,
  input  word_t addr,
  input  word_t wdata,
  output word_t rdata
);

  localparam int depth = 1 << addrWidth;

  word_t mem [depth];

  // contents start at zero
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // upper address bits wrap onto the array
  always @(posedge clk) begin
    if (we) begin
      mem[addr[addrWidth-1:0]] <= wdata;
    end
  end

  assign rdata = mem[addr[addrWidth-1:0]];

endmodule

// ==== hw/registerFile.sv ====
module registerFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t rs,
  input  regIdx_t rt,
  input  regIdx_t rd,
  input  logic    we,
  input  word_t   wdata,
  input  regIdx_t dbgReg,
  output word_t   srcA,
  output word_t   srcB,
  output word_t   dbgData
);

  word_t regs [16];

  // all sixteen are general purpose, none is tied to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= wdata;
    end
  end

  // reads see the old value until the edge
  assign srcA    = regs[rs];
  assign srcB    = regs[rt];
  assign dbgData = regs[dbgReg];

endmodule

// ==== sim/cpuTb.sv ====
module cpuTb import cpuPkg::*; ();

  // 32 setup words, then 40 random words ending in HLT
  localparam int progLen = 72;
  localparam int timeoutCycles = 200;

  logic    clk;
  logic    reset;
  logic    hlt;
  word_t   pc;
  logic    progWe;
  word_t   progAddr;
  word_t   progData;
  regIdx_t dbgReg;
  word_t   dbgData;

  integer seed = 32'hdb51;
  int     wordErrors = 0;
  int     bitErrors = 0;
  int     timeouts = 0;
  int     assertErrors;
  int     cycles;
  word_t  prog [256];
  // instruction-set model state
  word_t  mReg [16];
  word_t  mMem [256];
  word_t  mPc;
  logic   mN, mZ, mV;

  cpu #(.instAddrWidth(8), .dataAddrWidth(8)) cpu_i (
    .clk(clk), .reset(reset), .hlt(hlt), .pc(pc), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .dbgReg(dbgReg), .dbgData(dbgData)
  );

  always #10 clk = ~clk;

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      wordErrors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bitErrors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic buildProgram();
    int idx;
    int floor;
    int k;
    opcode_t op;
    idx = 0;
    // no branch may land past this point into a BR block
    floor = 0;
    for (int r = 0; r < 16; r++) begin
      prog[idx] = {opLlb, regIdx_t'(r), imm8_t'(randBelow(256))};
      prog[idx + 1] = {opLhb, regIdx_t'(r), imm8_t'(randBelow(256))};
      idx += 2;
    end
    while (idx < progLen - 1) begin
      op = opcode_t'(randBelow(16));
      if (op == opB) begin
        k = randBelow(4);
        if (idx + 1 + k > progLen - 1) k = progLen - 2 - idx;
        if (idx + 1 + k > floor) floor = idx + 1 + k;
        prog[idx] = {opB, cond_t'(randBelow(8)), off9_t'(k)};
        idx += 1;
      end else if (op == opBr && idx >= floor && idx + 7 <= progLen - 1) begin
        // r14 = captured pc+1 plus a step that lands past the BR
        k = 4 + randBelow(3);
        prog[idx] = {opPcs, 4'd14, 8'h00};
        prog[idx + 1] = {opLlb, 4'd13, imm8_t'(k)};
        prog[idx + 2] = {opLhb, 4'd13, 8'h00};
        prog[idx + 3] = {opAdd, 4'd14, 4'd14, 4'd13};
        prog[idx + 4] = {opBr, cond_t'(randBelow(8)), 1'b0, 4'd14, 4'd0};
        floor = idx + 1 + k;
        idx += 5;
      end else if (op == opLw || op == opSw) begin
        // r15 stays fixed, so all accesses share a 16-word window
        k = (op == opSw) ? randBelow(16) : randBelow(13);
        prog[idx] = {op, regIdx_t'(k), 4'd15, regIdx_t'(randBelow(16))};
        idx += 1;
      end else begin
        if (op == opBr || op == opHlt || op == opB) op = opcode_t'(randBelow(8));
        prog[idx] = {op, regIdx_t'(randBelow(13)), regIdx_t'(randBelow(16)),
                     regIdx_t'(randBelow(16))};
        idx += 1;
      end
    end
    prog[progLen - 1] = {opHlt, 12'h000};
  endtask

  function automatic logic condHolds(input logic [2:0] c);
    case (c)
      3'b000:  return !mZ;
      3'b001:  return mZ;
      3'b010:  return !mZ && !mN;
      3'b011:  return mN;
      3'b100:  return !mN;
      3'b101:  return mZ || mN;
      3'b110:  return mV;
      default: return 1'b1;
    endcase
  endfunction

  task automatic writeAndSetZ(input regIdx_t rd, input word_t value);
    mReg[rd] = value;
    mZ = (value == 16'h0000);
  endtask

  // retire one instruction in the model
  task automatic executeModel();
    word_t   ins;
    word_t   a;
    word_t   b;
    word_t   res;
    word_t   addr;
    word_t   nextPc;
    regIdx_t rd;
    int      s;
    ins = prog[mPc[7:0]];
    rd = ins[11:8];
    a = mReg[ins[7:4]];
    b = mReg[ins[3:0]];
    nextPc = mPc + 16'd1;
    addr = a + {{12{ins[3]}}, ins[3:0]};
    case (ins[15:12])
      opAdd, opSub: begin
        if (ins[15:12] == opAdd) s = int'($signed(a)) + int'($signed(b));
        else s = int'($signed(a)) - int'($signed(b));
        res = s[15:0];
        writeAndSetZ(rd, res);
        mN = res[15];
        mV = (s > 32767) || (s < -32768);
      end
      opXor: writeAndSetZ(rd, a ^ b);
      opAnd: mReg[rd] = a & b;
      opSll: writeAndSetZ(rd, a << b[3:0]);
      opSra, opRor: begin
        res = a;
        // one bit per step, the top bit refilled by sign or wrap
        for (int i = 0; i < int'(b[3:0]); i++) begin
          res = {(ins[15:12] == opSra) ? res[15] : res[0], res[15:1]};
        end
        writeAndSetZ(rd, res);
      end
      opLw:  mReg[rd] = mMem[addr[7:0]];
      opSw:  mMem[addr[7:0]] = mReg[rd];
      opLlb: mReg[rd] = {mReg[rd][15:8], ins[7:0]};
      opLhb: mReg[rd] = {ins[7:0], mReg[rd][7:0]};
      opB:   if (condHolds(ins[11:9])) nextPc = mPc + 16'd1 + {{7{ins[8]}}, ins[8:0]};
      opBr:  if (condHolds(ins[11:9])) nextPc = a;
      opPcs: mReg[rd] = mPc + 16'd1;
      opHlt: nextPc = mPc;
      default: ;
    endcase
    mPc = nextPc;
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    dbgReg = '0;
    for (int i = 0; i < 256; i++) begin
      prog[i] = '0;
      mMem[i] = '0;
    end
    for (int i = 0; i < 16; i++) mReg[i] = '0;
    {mN, mZ, mV} = 3'b000;
    mPc = '0;
    buildProgram();
    // program port writes one word per cycle while reset is high
    for (int i = 0; i < progLen; i++) begin
      @(negedge clk);
      progWe = 1'b1;
      progAddr = word_t'(i);
      progData = prog[i];
    end
    @(negedge clk);
    progWe = 1'b0;
    repeat (4) @(negedge clk);
    checkWord("pc", pc, 16'h0000);
    checkBit("hlt", hlt, 1'b0);
    reset = 1'b0;
    cycles = 0;
    while (hlt !== 1'b1 && cycles < timeoutCycles) begin
      executeModel();
      @(negedge clk);
      cycles++;
      checkWord("pc", pc, mPc);
      checkBit("hlt", hlt, prog[mPc[7:0]][15:12] == opHlt);
    end
    if (hlt !== 1'b1) begin
      timeouts++;
      $display("timeout: hlt did not rise within %0d cycles", timeoutCycles);
    end else begin
      repeat (5) begin
        @(negedge clk);
        checkWord("pc", pc, mPc);
        checkBit("hlt", hlt, 1'b1);
      end
      for (int r = 0; r < 16; r++) begin
        @(negedge clk);
        dbgReg = regIdx_t'(r);
        @(negedge clk);
        checkWord($sformatf("dbgData r%0d", r), dbgData, mReg[r]);
      end
    end
    assertErrors = cpu_i.checker_i.assertErrors;
    $display("errors: word %0d, bit %0d, timeout %0d, assertion %0d",
             wordErrors, bitErrors, timeouts, assertErrors);
    if (wordErrors + bitErrors + timeouts + assertErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/cpu_checker.sv ====
module cpuChecker import cpuPkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  hlt,
  input word_t pc,
  input word_t dbgData,
  input word_t memAddr,
  input word_t memData
);

  int assertErrors = 0;

  // every register reads back cleared after an edge in reset
  noRegWriteInReset: assert property (@(posedge clk) reset |=> dbgData == '0)
    else begin
      assertErrors++;
      $error("register written while reset is high");
    end

  // an edge in reset leaves the addressed data word as it was
  noMemWriteInReset: assert property (
    @(posedge clk) reset ##1 $stable(memAddr) |-> $stable(memData))
    else begin
      assertErrors++;
      $error("data memory written while reset is high");
    end

  pcHoldsOnHalt: assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(pc))
    else begin
      assertErrors++;
      $error("pc moved while hlt was high");
    end

  noHaltInReset: assert property (@(posedge clk) reset |-> !hlt)
    else begin
      assertErrors++;
      $error("hlt high during reset");
    end

endmodule

bind cpu cpuChecker checker_i (
  .clk(clk), .reset(reset), .hlt(hlt), .pc(pc), .dbgData(dbgData), .memAddr(result),
  .memData(dataOut)
);

// ==== tb.f ====
hw/cpuPkg.sv
hw/alu.sv
hw/decoder.sv
hw/branchUnit.sv
hw/registerFile.sv
hw/memory.sv
hw/cpu.sv
sim/cpu_checker.sv
sim/cpuTb.sv
